/* hw/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// register and operand width
`define CORE_DATA_W 16

// register file depth
`define CORE_NREGS 8

// width of DR, SR1 and SR2 fields
`define CORE_RIDX_W 3

// opcode field in instr[15:12]
`define CORE_OP_W 4

// shift-add iterations per multiply, one per product bit kept
`define CORE_MUL_STEPS 16

`endif

/* hw/core_pkg.sv */
`default_nettype none

`include "core_defines.svh"

package core_pkg;

    // supported opcodes, anything else is accepted as a no-op
    typedef enum logic [`CORE_OP_W-1:0] {
        OP_ADD = 4'b0000,
        OP_NOT = 4'b0001,
        OP_SUB = 4'b0010,
        OP_AND = 4'b0011,
        OP_OR  = 4'b0100,
        OP_XOR = 4'b0101,
        OP_MUL = 4'b0110,
        OP_SHL = 4'b1000,
        OP_SHR = 4'b1001
    } opcode_e;

    // controller states
    typedef enum logic [1:0] {
        IDLE     = 2'b00,
        EXEC     = 2'b01,
        MUL_WAIT = 2'b10,
        WRITE    = 2'b11
    } state_e;

    // instruction word, opcode in the top bits
    // for SHR the top bit of sr1 (instr[8]) selects logical (1) or arithmetic (0)
    typedef struct packed {
        opcode_e                 opcode;
        logic [`CORE_RIDX_W-1:0] dr;
        logic [`CORE_RIDX_W-1:0] sr1;
        logic                    imm_mode;
        logic [4:0]              low;
    } instr_t;

    // operation request into the ALU and the multiplier
    typedef struct packed {
        opcode_e                 op;
        logic [`CORE_DATA_W-1:0] a;
        logic [`CORE_DATA_W-1:0] b;
        logic                    shift_logical;
    } alu_req_t;

    // flat register view, register 0 in the low bits
    typedef logic [`CORE_NREGS-1:0][`CORE_DATA_W-1:0] reg_view_t;

endpackage

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`CORE_RIDX_W-1:0] rd_a_idx,
    input  logic [`CORE_RIDX_W-1:0] rd_b_idx,
    output logic [`CORE_DATA_W-1:0] rd_a_data,
    output logic [`CORE_DATA_W-1:0] rd_b_data,
    input  logic                    wr_en,
    input  logic [`CORE_RIDX_W-1:0] wr_idx,
    input  logic [`CORE_DATA_W-1:0] wr_data,
    output core_pkg::reg_view_t     regs
);

    import core_pkg::*;

    reg_view_t rf;

    // all registers are architectural state, cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rf <= '0;
        end else if (wr_en) begin
            rf[wr_idx] <= wr_data;
        end
    end

    // combinational read ports
    // a read of the register being written returns the old value
    always_comb begin
        rd_a_data = rf[rd_a_idx];
        rd_b_data = rf[rd_b_idx];
    end

    assign regs = rf;

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module alu (
    input  core_pkg::alu_req_t      req,
    output logic [`CORE_DATA_W-1:0] result
);

    import core_pkg::*;

    logic shr_fill;

    // bit shifted into the top on SHR
    assign shr_fill = req.shift_logical ? 1'b0 : req.a[`CORE_DATA_W-1];

    // everything wraps at the data width
    always_comb begin
        case (req.op)
            OP_ADD: begin
                result = req.a + req.b;
            end
            OP_SUB: begin
                result = req.a - req.b;
            end
            OP_AND: begin
                result = req.a & req.b;
            end
            OP_OR: begin
                result = req.a | req.b;
            end
            OP_XOR: begin
                result = req.a ^ req.b;
            end
            OP_NOT: begin
                result = ~req.a;
            end
            OP_SHL: begin
                // arithmetic and logical left shifts are identical
                result = {req.a[`CORE_DATA_W-2:0], 1'b0};
            end
            OP_SHR: begin
                result = {shr_fill, req.a[`CORE_DATA_W-1:1]};
            end
            default: begin
                // MUL goes to the multiplier, unsupported ops give nothing
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module mul_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  core_pkg::alu_req_t      req,
    output logic                    done,
    output logic [`CORE_DATA_W-1:0] product
);

    localparam int STEP_W = $clog2(`CORE_MUL_STEPS);

    logic                    running;
    logic [STEP_W-1:0]       step;
    logic [`CORE_DATA_W-1:0] mcand;
    logic [`CORE_DATA_W-1:0] mplier;

    // step counter, the load cycle already covers bit 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running <= 1'b0;
            step    <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                step    <= STEP_W'(`CORE_MUL_STEPS - 1);
            end else if (running) begin
                step <= step - 1'b1;
                if (step == STEP_W'(1)) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // shift-add datapath, upper product bits are dropped as they overflow
    // product holds its value until the next start
    always_ff @(posedge clk) begin
        if (start) begin
            product <= req.b[0] ? req.a : '0;
            mcand   <= {req.a[`CORE_DATA_W-2:0], 1'b0};
            mplier  <= {1'b0, req.b[`CORE_DATA_W-1:1]};
        end else if (running) begin
            if (mplier[0]) begin
                product <= product + mcand;
            end
            mcand  <= {mcand[`CORE_DATA_W-2:0], 1'b0};
            mplier <= {1'b0, mplier[`CORE_DATA_W-1:1]};
        end
    end

    // no back-pressure, so a second start would corrupt the running multiply
    a_no_start_while_running: assert property (
        @(posedge clk) disable iff (!rst_n) start |-> !running
    );

endmodule

`default_nettype wire

/* hw/exec_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module exec_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    instr_valid,
    input  core_pkg::instr_t        instr,
    output logic [`CORE_RIDX_W-1:0] rd_a_idx,
    output logic [`CORE_RIDX_W-1:0] rd_b_idx,
    input  logic [`CORE_DATA_W-1:0] rd_a_data,
    input  logic [`CORE_DATA_W-1:0] rd_b_data,
    output core_pkg::alu_req_t      req,
    input  logic [`CORE_DATA_W-1:0] alu_result,
    output logic                    mul_start,
    input  logic                    mul_done,
    input  logic [`CORE_DATA_W-1:0] mul_result,
    output logic                    wr_en,
    output logic [`CORE_RIDX_W-1:0] wr_idx,
    output logic [`CORE_DATA_W-1:0] wr_data,
    output logic                    busy,
    output logic                    done
);

    import core_pkg::*;

    state_e state;
    state_e state_d;
    instr_t instr_q;
    logic   is_alu_op;
    logic   is_shift;
    logic   is_mul;

    always_comb begin
        case (instr_q.opcode)
            OP_ADD, OP_NOT, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR: begin
                is_alu_op = 1'b1;
            end
            default: begin
                is_alu_op = 1'b0;
            end
        endcase
    end

    assign is_shift = (instr_q.opcode == OP_SHL) || (instr_q.opcode == OP_SHR);
    assign is_mul   = (instr_q.opcode == OP_MUL);

    // shifts work in place on DR, everything else reads SR1
    assign rd_a_idx = is_shift ? instr_q.dr : instr_q.sr1;
    assign rd_b_idx = instr_q.low[`CORE_RIDX_W-1:0];

    assign req.op            = instr_q.opcode;
    assign req.a             = rd_a_data;
    assign req.b             = instr_q.imm_mode ?
                               {{(`CORE_DATA_W-5){1'b0}}, instr_q.low} : rd_b_data;
    assign req.shift_logical = instr_q.sr1[`CORE_RIDX_W-1];

    assign mul_start = (state == EXEC) && is_mul;

    // write-back lands on the edge that raises done
    assign wr_en   = ((state == EXEC) && is_alu_op) || ((state == MUL_WAIT) && mul_done);
    assign wr_idx  = instr_q.dr;
    assign wr_data = (state == MUL_WAIT) ? mul_result : alu_result;

    always_comb begin
        state_d = state;
        case (state)
            IDLE:     if (instr_valid) state_d = EXEC;
            EXEC:     state_d = is_mul ? MUL_WAIT : WRITE;
            MUL_WAIT: if (mul_done) state_d = WRITE;
            default:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_d;
        end
    end

    // strobes while busy are dropped here
    always_ff @(posedge clk) begin
        if (state == IDLE && instr_valid) begin
            instr_q <= instr;
        end
    end

    assign busy = (state != IDLE);
    assign done = (state == WRITE);

    a_done_single: assert property (
        @(posedge clk) disable iff (!rst_n) done |=> !done
    );

    a_mul_done_in_wait: assert property (
        @(posedge clk) disable iff (!rst_n) mul_done |-> state == MUL_WAIT
    );

endmodule

`default_nettype wire

/* hw/exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module exec_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  core_pkg::instr_t    instr,
    output logic                busy,
    output logic                done,
    output core_pkg::reg_view_t regs
);

    import core_pkg::*;

    logic [`CORE_RIDX_W-1:0] rd_a_idx;
    logic [`CORE_RIDX_W-1:0] rd_b_idx;
    logic [`CORE_DATA_W-1:0] rd_a_data;
    logic [`CORE_DATA_W-1:0] rd_b_data;
    logic                    wr_en;
    logic [`CORE_RIDX_W-1:0] wr_idx;
    logic [`CORE_DATA_W-1:0] wr_data;
    alu_req_t                req;
    logic [`CORE_DATA_W-1:0] alu_result;
    logic                    mul_start;
    logic                    mul_done;
    logic [`CORE_DATA_W-1:0] mul_result;

    exec_ctrl u_exec_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_valid(instr_valid),
        .instr      (instr),
        .rd_a_idx   (rd_a_idx),
        .rd_b_idx   (rd_b_idx),
        .rd_a_data  (rd_a_data),
        .rd_b_data  (rd_b_data),
        .req        (req),
        .alu_result (alu_result),
        .mul_start  (mul_start),
        .mul_done   (mul_done),
        .mul_result (mul_result),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .busy       (busy),
        .done       (done)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_a_idx (rd_a_idx),
        .rd_b_idx (rd_b_idx),
        .rd_a_data(rd_a_data),
        .rd_b_data(rd_b_data),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .regs     (regs)
    );

    alu u_alu (
        .req   (req),
        .result(alu_result)
    );

    mul_unit u_mul_unit (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (mul_start),
        .req    (req),
        .done   (mul_done),
        .product(mul_result)
    );

endmodule

`default_nettype wire

/* testbench/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

    // expected register contents, updated once per accepted instruction
    logic [`CORE_DATA_W-1:0] model_regs [`CORE_NREGS];

    // executes one instruction word on the model registers
    // opcode in 15:12, DR in 11:9, SR1 in 8:6, imm flag in 5, imm5 in 4:0, SR2 in 2:0
    function automatic void model_exec(input logic [15:0] word);
        logic [2:0]  dr;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] d;
        logic [31:0] prod;
        dr   = word[11:9];
        a    = model_regs[word[8:6]];
        d    = model_regs[dr];
        b    = word[5] ? {11'd0, word[4:0]} : model_regs[word[2:0]];
        prod = a * b;
        case (word[15:12])
            4'h0: model_regs[dr] = a + b;
            4'h1: model_regs[dr] = ~a;
            4'h2: model_regs[dr] = a - b;
            4'h3: model_regs[dr] = a & b;
            4'h4: model_regs[dr] = a | b;
            4'h5: model_regs[dr] = a ^ b;
            // only the low half of the product is kept
            4'h6: model_regs[dr] = prod[15:0];
            4'h8: model_regs[dr] = {d[14:0], 1'b0};
            // bit 8 set means logical, clear means arithmetic
            4'h9: model_regs[dr] = word[8] ? {1'b0, d[15:1]} : {d[15], d[15:1]};
            default: begin
                // unsupported opcodes retire without a write
            end
        endcase
    endfunction

`endif

/* testbench/tb_exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module tb_exec_core;

    import core_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_SEED     = `CORE_NREGS;
    localparam int N_LOGIC    = 24;
    localparam int N_SHIFT    = 12;
    localparam int N_MUL      = 8;
    localparam int N_BUSY     = 3;
    localparam int N_UNSUP    = 4;
    // reset check plus six directed shift steps
    localparam int NUM_TESTS  = 7 + N_SEED + N_LOGIC + N_SHIFT + N_MUL + N_BUSY + N_UNSUP;
    localparam longint WATCHDOG_NS =
        longint'(NUM_TESTS) * (`CORE_MUL_STEPS + 4) * CLK_PERIOD + 8 * CLK_PERIOD;

    logic      clk;
    logic      rst_n;
    logic      instr_valid;
    instr_t    instr;
    logic      busy;
    logic      done;
    reg_view_t regs;

    logic [31:0] rng_state;
    int          test_num;
    int          pass_count;
    int          fail_count;

    logic [3:0] logic_ops [5] = '{4'h0, 4'h2, 4'h3, 4'h4, 4'h5};
    logic [3:0] shift_ops [3] = '{4'h1, 4'h8, 4'h9};
    logic [3:0] unsup_ops [7] = '{4'h7, 4'hA, 4'hB, 4'hC, 4'hD, 4'hE, 4'hF};

    `include "tb_model.svh"

    exec_core u_exec_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_valid(instr_valid),
        .instr      (instr),
        .busy       (busy),
        .done       (done),
        .regs       (regs)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, done never came", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // random operand fields under a fixed opcode
    function automatic logic [15:0] rand_word(input logic [3:0] op);
        logic [31:0] r;
        r = next_rand();
        return {op, r[11:0]};
    endfunction

    function automatic int compare_regs();
        int mismatches;
        mismatches = 0;
        for (int i = 0; i < `CORE_NREGS; i++) begin
            if (regs[i] !== model_regs[i]) begin
                $display("Fail regs[%0d] expected %04h actual %04h", i, model_regs[i], regs[i]);
                mismatches++;
            end
        end
        return mismatches;
    endfunction

    task automatic report_test(input string what, input int errors);
        if (errors == 0) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %0d %s: %s", test_num, what, (errors == 0) ? "ok" : "mismatch");
        test_num++;
    endtask

    task automatic check_reset();
        int errors;
        errors = 0;
        if (busy !== 1'b0) begin
            $display("Fail busy expected %h actual %h", 1'b0, busy);
            errors++;
        end
        if (done !== 1'b0) begin
            $display("Fail done expected %h actual %h", 1'b0, done);
            errors++;
        end
        errors += compare_regs();
        report_test("after reset", errors);
    endtask

    // one strobe, an optional second strobe while busy, then the check on done
    task automatic run_test(input logic [15:0] word, input logic inject,
                            input logic [15:0] extra);
        int   cycles;
        int   errors;
        int   exp_cycles;
        logic busy_ok;
        cycles     = 1;
        errors     = 0;
        busy_ok    = 1'b1;
        exp_cycles = (word[15:12] == 4'h6) ? `CORE_MUL_STEPS + 2 : 2;
        @(posedge clk);
        #2;
        instr_valid = 1'b1;
        instr       = instr_t'(word);
        @(posedge clk);
        #2;
        instr_valid = 1'b0;
        model_exec(word);
        forever begin
            if (!busy && busy_ok) begin
                $display("Fail busy expected %h actual %h", 1'b1, busy);
                busy_ok = 1'b0;
                errors++;
            end
            if (done) break;
            instr_valid = inject && (cycles == 3);
            if (instr_valid) begin
                instr = instr_t'(extra);
            end
            @(posedge clk);
            #2;
            cycles++;
        end
        instr_valid = 1'b0;
        if (cycles != exp_cycles) begin
            $display("done rose %0d cycles after sampling, expected %0d", cycles, exp_cycles);
            errors++;
        end
        errors += compare_regs();
        report_test($sformatf("instr %04h", word), errors);
    endtask

    initial begin
        logic [31:0] r;
        logic [15:0] w;
        logic [15:0] x;
        rng_state   = 32'd83;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        test_num    = 0;
        pass_count  = 0;
        fail_count  = 0;
        foreach (model_regs[i]) model_regs[i] = '0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_reset();
        // every register starts from zero, so ADD immediate just loads imm5
        for (int i = 0; i < N_SEED; i++) begin
            r = next_rand();
            run_test({4'h0, 3'(i), 3'(i), 1'b1, r[4:0]}, 1'b0, '0);
        end
        for (int i = 0; i < N_LOGIC; i++) begin
            r = next_rand();
            run_test(rand_word(logic_ops[r % 5]), 1'b0, '0);
        end
        // force the top bit of r6, then shift it both ways
        r = next_rand();
        run_test({4'h2, 3'd6, 3'd6, 1'b0, 5'd6}, 1'b0, '0);
        run_test({4'h1, 3'd6, 3'd6, 1'b0, 5'd0}, 1'b0, '0);
        run_test({4'h5, 3'd6, 3'd6, 1'b1, r[4:0]}, 1'b0, '0);
        run_test({4'h9, 3'd6, 3'b000, 1'b0, 5'd0}, 1'b0, '0);
        run_test({4'h9, 3'd6, 3'b100, 1'b0, 5'd0}, 1'b0, '0);
        run_test({4'h8, 3'd6, 3'b000, 1'b0, 5'd0}, 1'b0, '0);
        for (int i = 0; i < N_SHIFT; i++) begin
            r = next_rand();
            run_test(rand_word(shift_ops[r % 3]), 1'b0, '0);
        end
        for (int i = 0; i < N_MUL; i++) begin
            run_test(rand_word(4'h6), 1'b0, '0);
        end
        // the extra ADD would change a register if it were accepted
        for (int i = 0; i < N_BUSY; i++) begin
            w = rand_word(4'h6);
            x = rand_word(4'h0) | 16'h0021;
            run_test(w, 1'b1, x);
        end
        for (int i = 0; i < N_UNSUP; i++) begin
            r = next_rand();
            run_test(rand_word(unsup_ops[r % 7]), 1'b0, '0);
        end
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+hw
+incdir+testbench
hw/core_pkg.sv
hw/reg_file.sv
hw/alu.sv
hw/mul_unit.sv
hw/exec_ctrl.sv
hw/exec_core.sv
testbench/tb_exec_core.sv
